// File: build.f
+incdir+common
common/eeprom_pkg.sv
eeprom_wr/serial_bit_engine.sv
eeprom_wr/eeprom_wr.sv
design/eeprom_ctrl_top.sv
bench/eeprom_model.sv
bench/tb_eeprom_ctrl_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_eeprom_ctrl_top
FILELIST  := build.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

SRCS := $(shell grep -v '^+' $(FILELIST)) common/eeprom_cfg.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^TB PASSED$$'

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_eeprom_ctrl_top.sv
`default_nettype none
`include "eeprom_cfg.svh"

module tb_eeprom_ctrl_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_OPS      = 21;
    localparam int CLK_PERIOD = 20;
    localparam int OP_CYCLES  = 50 * `EE_PHASES; // covers the longest read
    localparam int KIND_WR    = 0;
    localparam int KIND_RD    = 1;
    localparam int KIND_BUSY  = 2; // write plus a strobe while busy

    logic                  CLK;
    logic                  RESET;
    logic                  wr;
    logic                  rd;
    logic [`EE_ADDR_W-1:0] addr;
    logic [`EE_DATA_W-1:0] data_drv;
    logic                  data_oe;
    logic                  respond;
    logic                  proto_err;
    wire  [`EE_DATA_W-1:0] data;
    wire                   sda;
    wire                   scl;
    wire                   ack;
    wire                   nack;
    int                    ack_cnt = 0;

    string                 t_name     [N_OPS];
    int                    t_kind     [N_OPS];
    logic [`EE_ADDR_W-1:0] t_addr     [N_OPS];
    logic [`EE_DATA_W-1:0] t_wdata    [N_OPS];
    logic                  t_resp     [N_OPS];
    logic [`EE_DATA_W-1:0] t_exp      [N_OPS];
    logic                  t_exp_nack [N_OPS];
    logic [`EE_DATA_W-1:0] shadow     [1 << `EE_ADDR_W];

    assign data = data_oe ? data_drv : {`EE_DATA_W{1'bz}};
    pullup (sda);

    eeprom_ctrl_top eeprom_ctrl_top_inst (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .data  (data),
        .sda   (sda),
        .scl   (scl),
        .ack   (ack),
        .nack  (nack)
    );

    eeprom_model u_mem (
        .scl       (scl),
        .sda       (sda),
        .respond   (respond),
        .proto_err (proto_err)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    always @(negedge CLK) begin
        if (ack === 1'b1) begin
            ack_cnt <= ack_cnt + 1;
        end
    end

    initial begin
        #(N_OPS * OP_CYCLES * CLK_PERIOD);
        $display("timeout waiting for ack");
        $display("TB FAILED");
        $fatal(1);
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    // bus errors seen by the model end the run at once
    always @(negedge CLK) begin
        assert (proto_err !== 1'b1) else
            abort_run("the EEPROM model saw a bus protocol error");
    end

    task automatic set_entry(input int i, input string name, input int kind,
                             input logic [`EE_ADDR_W-1:0] a,
                             input logic [`EE_DATA_W-1:0] d, input logic resp);
        t_name[i]  = name;
        t_kind[i]  = kind;
        t_addr[i]  = a;
        t_wdata[i] = d;
        t_resp[i]  = resp;
    endtask

    // memory contents follow completed writes in table order
    task automatic predict();
        for (int i = 0; i < N_OPS; i++) begin
            t_exp_nack[i] = !t_resp[i];
            t_exp[i]      = shadow[t_addr[i]];
            if (t_kind[i] != KIND_RD && t_resp[i]) begin
                shadow[t_addr[i]] = t_wdata[i];
            end
        end
    endtask

    task automatic strobe(input logic is_wr, input logic [`EE_ADDR_W-1:0] a,
                          input logic [`EE_DATA_W-1:0] d);
        @(posedge CLK);
        #2;
        addr     = a;
        wr       = is_wr;
        rd       = !is_wr;
        data_drv = d;
        data_oe  = is_wr;
        @(posedge CLK);
        #2;
        wr      = 1'b0;
        rd      = 1'b0;
        data_oe = 1'b0;
    endtask

    task automatic run_entry(input int i);
        logic [`EE_DATA_W-1:0] got;
        logic                  got_nack;
        respond = t_resp[i];
        strobe(t_kind[i] != KIND_RD, t_addr[i], t_wdata[i]);
        if (t_kind[i] == KIND_BUSY) begin
            repeat (10) @(posedge CLK);
            strobe(1'b1, t_addr[i], ~t_wdata[i]); // must be ignored
        end
        do @(negedge CLK); while (ack !== 1'b1);
        got      = data;
        got_nack = nack;
        assert (got_nack === t_exp_nack[i]) else
            abort_run($sformatf("ERR %s expected nack %0b actual %0b",
                                t_name[i], t_exp_nack[i], got_nack));
        if (t_kind[i] == KIND_RD && t_resp[i]) begin
            assert (got === t_exp[i]) else
                abort_run($sformatf("ERR %s expected %02h actual %02h",
                                    t_name[i], t_exp[i], got));
        end
    endtask

    initial begin
        logic [`EE_ADDR_W-1:0] ra [4];
        logic [`EE_DATA_W-1:0] rdat [4];
        void'($urandom(32'he000d828));
        RESET    = 1'b1;
        wr       = 1'b0;
        rd       = 1'b0;
        addr     = '0;
        data_drv = '0;
        data_oe  = 1'b0;
        respond  = 1'b1;
        for (int k = 0; k < 4; k++) begin
            ra[k]   = `EE_ADDR_W'($urandom());
            rdat[k] = `EE_DATA_W'($urandom());
        end
        for (int k = 0; k < (1 << `EE_ADDR_W); k++) shadow[k] = 8'(k * 37) ^ 8'(k >> 3);
        set_entry(0, "wr_basic", KIND_WR, 11'h005, 8'h3c, 1'b1);
        set_entry(1, "rd_basic", KIND_RD, 11'h005, 8'h00, 1'b1);
        set_entry(2, "wr_blk0", KIND_WR, 11'h0a7, 8'h11, 1'b1);
        set_entry(3, "wr_blk5", KIND_WR, 11'h5a7, 8'h55, 1'b1);
        set_entry(4, "wr_blk7", KIND_WR, 11'h7a7, 8'h77, 1'b1);
        set_entry(5, "rd_blk5", KIND_RD, 11'h5a7, 8'h00, 1'b1);
        set_entry(6, "rd_blk0", KIND_RD, 11'h0a7, 8'h00, 1'b1);
        set_entry(7, "rd_blk7", KIND_RD, 11'h7a7, 8'h00, 1'b1);
        for (int k = 0; k < 4; k++) begin
            set_entry(8 + k, $sformatf("wr_rnd%0d", k), KIND_WR, ra[k], rdat[k], 1'b1);
        end
        set_entry(12, "rd_rnd3", KIND_RD, ra[3], 8'h00, 1'b1);
        set_entry(13, "rd_rnd1", KIND_RD, ra[1], 8'h00, 1'b1);
        set_entry(14, "rd_rnd0", KIND_RD, ra[0], 8'h00, 1'b1);
        set_entry(15, "rd_rnd2", KIND_RD, ra[2], 8'h00, 1'b1);
        set_entry(16, "wr_noresp", KIND_WR, 11'h005, 8'hee, 1'b0);
        set_entry(17, "rd_noresp", KIND_RD, 11'h5a7, 8'h00, 1'b0);
        set_entry(18, "rd_after_nack", KIND_RD, 11'h005, 8'h00, 1'b1);
        set_entry(19, "wr_busy", KIND_BUSY, 11'h123, 8'h9a, 1'b1);
        set_entry(20, "rd_busy", KIND_RD, 11'h123, 8'h00, 1'b1);
        predict();

        repeat (16) @(posedge CLK);
        #2 RESET = 1'b0;
        @(negedge CLK);
        assert (scl === 1'b1 && sda === 1'b1 && ack === 1'b0) else
            abort_run($sformatf("ERR reset_idle expected scl 1 sda 1 ack 0 actual scl %b sda %b ack %b",
                                scl, sda, ack));

        for (int i = 0; i < N_OPS; i++) begin
            run_entry(i);
        end

        repeat (20) @(negedge CLK);
        assert (ack_cnt == N_OPS) begin
            $display("TB PASSED");
            $finish;
        end else begin
            abort_run($sformatf("ERR ack_count expected %0d actual %0d", N_OPS, ack_cnt));
        end
    end

endmodule

`default_nettype wire

// File: bench/eeprom_model.sv
`default_nettype none
`include "eeprom_cfg.svh"

module eeprom_model (
    input  wire  scl,
    inout  wire  sda,
    input  wire  respond,
    output logic proto_err
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_SIZE = 1 << `EE_ADDR_W;

    localparam logic [2:0] M_IDLE = 3'd0;
    localparam logic [2:0] M_CTRL = 3'd1;
    localparam logic [2:0] M_ADDR = 3'd2;
    localparam logic [2:0] M_DATA = 3'd3;
    localparam logic [2:0] M_READ = 3'd4;
    localparam logic [2:0] M_WAIT = 3'd5; // ignore bus until start/stop

    logic [`EE_DATA_W-1:0] mem [MEM_SIZE];
    logic [2:0]            state;
    logic [2:0]            next_state;
    logic [3:0]            bit_cnt;
    logic [`EE_DATA_W-1:0] shreg;
    logic [`EE_DATA_W-1:0] tx;
    logic [2:0]            blk;
    logic [`EE_DATA_W-1:0] word;
    logic                  sda_low;
    logic                  skip_fall; // SCL fall right after a start
    logic                  scl_q;
    logic                  sda_q;

    assign sda = sda_low ? 1'b0 : 1'bz;

    task automatic on_start();
        if (state != M_IDLE && bit_cnt != 4'd0) begin
            $display("protocol error: SDA fell while SCL high inside a byte");
            proto_err = 1'b1;
        end
        state     = M_CTRL;
        bit_cnt   = 4'd0;
        sda_low   = 1'b0;
        skip_fall = 1'b1;
    endtask

    task automatic on_stop();
        if (state != M_IDLE && bit_cnt != 4'd0) begin
            $display("protocol error: SDA rose while SCL high inside a byte");
            proto_err = 1'b1;
        end
        state   = M_IDLE;
        bit_cnt = 4'd0;
        sda_low = 1'b0;
    endtask

    task automatic on_rise();
        if (state == M_READ) begin
            if (bit_cnt == 4'd8) begin
                next_state = M_WAIT; // single byte, ack or nack ends it
            end
        end else if (state != M_IDLE && state != M_WAIT && bit_cnt < 4'd8) begin
            shreg = {shreg[`EE_DATA_W-2:0], (sda === 1'b1)};
        end
    endtask

    // all bytes are complete here, decide ack
    task automatic byte_done();
        case (state)
            M_CTRL: begin
                if (shreg[7:4] == `EE_DEV_CODE && respond) begin
                    blk        = shreg[3:1];
                    sda_low    = 1'b1;
                    next_state = shreg[0] ? M_READ : M_ADDR;
                end else begin
                    next_state = M_WAIT;
                end
            end
            M_ADDR: begin
                sda_low    = respond;
                word       = shreg;
                next_state = respond ? M_DATA : M_WAIT;
            end
            M_DATA: begin
                if (respond) begin
                    mem[{blk, word}] = shreg;
                end
                sda_low    = respond;
                next_state = M_WAIT;
            end
            default: sda_low = 1'b0; // master owns the ack bit
        endcase
    endtask

    task automatic on_fall();
        if (skip_fall) begin
            skip_fall = 1'b0;
        end else if (state != M_IDLE && state != M_WAIT) begin
            if (bit_cnt < 4'd7) begin
                bit_cnt = bit_cnt + 4'd1;
                if (state == M_READ) begin
                    sda_low = ~tx[3'd7 - bit_cnt[2:0]];
                end
            end else if (bit_cnt == 4'd7) begin
                bit_cnt = 4'd8;
                byte_done();
            end else begin
                bit_cnt = 4'd0;
                sda_low = 1'b0;
                state   = next_state;
                if (state == M_READ) begin
                    tx      = mem[{blk, word}];
                    sda_low = ~tx[7];
                end
            end
        end
    endtask

    initial begin
        for (int i = 0; i < MEM_SIZE; i++) begin
            mem[i] = 8'(i * 37) ^ 8'(i >> 3);
        end
        state      = M_IDLE;
        next_state = M_IDLE;
        bit_cnt    = 4'd0;
        shreg      = '0;
        tx         = '0;
        blk        = '0;
        word       = '0;
        sda_low    = 1'b0;
        skip_fall  = 1'b0;
        proto_err  = 1'b0;
        scl_q      = 1'b1;
        sda_q      = 1'b1;
        forever begin
            @(scl or sda);
            if (scl !== scl_q) begin
                if (scl === 1'b1) begin
                    on_rise();
                end else begin
                    on_fall();
                end
            end else if (scl === 1'b1 && sda !== sda_q) begin
                if (sda === 1'b0) begin
                    on_start();
                end else begin
                    on_stop();
                end
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

`default_nettype wire

// File: design/eeprom_ctrl_top.sv
`default_nettype none
`include "eeprom_cfg.svh"

module eeprom_ctrl_top
    import eeprom_pkg::*;
(
    input  wire                  CLK,
    input  wire                  RESET,
    input  wire                  wr,
    input  wire                  rd,
    input  wire [`EE_ADDR_W-1:0] addr,
    inout  wire [`EE_DATA_W-1:0] data,
    inout  wire                  sda,
    output wire                  scl,
    output wire                  ack,
    output wire                  nack
);

    logic                  op_go;
    bit_op_t               op;
    logic [`EE_DATA_W-1:0] tx_byte;
    logic                  master_nack;
    logic                  op_done;
    logic                  slave_nack;
    logic [`EE_DATA_W-1:0] rx_byte;
    logic [`EE_DATA_W-1:0] rd_data;
    logic                  rd_data_en;
    logic                  sda_drive_low;

    // open drain, pull-up gives the high level
    assign sda  = sda_drive_low ? 1'b0 : 1'bz;
    assign data = rd_data_en ? rd_data : {`EE_DATA_W{1'bz}};

    eeprom_wr u_ctrl (
        .CLK         (CLK),
        .RESET       (RESET),
        .wr          (wr),
        .rd          (rd),
        .addr        (addr),
        .wr_data     (data),
        .op_done     (op_done),
        .slave_nack  (slave_nack),
        .rx_byte     (rx_byte),
        .rd_data     (rd_data),
        .rd_data_en  (rd_data_en),
        .ack         (ack),
        .nack        (nack),
        .op_go       (op_go),
        .op          (op),
        .tx_byte     (tx_byte),
        .master_nack (master_nack)
    );

    serial_bit_engine u_engine (
        .CLK           (CLK),
        .RESET         (RESET),
        .op_go         (op_go),
        .op            (op),
        .tx_byte       (tx_byte),
        .master_nack   (master_nack),
        .sda_in        (sda),
        .op_done       (op_done),
        .slave_nack    (slave_nack),
        .rx_byte       (rx_byte),
        .scl           (scl),
        .sda_drive_low (sda_drive_low)
    );

endmodule

`default_nettype wire

// File: eeprom_wr/eeprom_wr.sv
`default_nettype none
`include "eeprom_cfg.svh"

module eeprom_wr
    import eeprom_pkg::*;
(
    input  wire                   CLK,
    input  wire                   RESET,
    input  wire                   wr,
    input  wire                   rd,
    input  wire [`EE_ADDR_W-1:0]  addr,
    input  wire [`EE_DATA_W-1:0]  wr_data,
    input  wire                   op_done,
    input  wire                   slave_nack,
    input  wire [`EE_DATA_W-1:0]  rx_byte,
    output logic [`EE_DATA_W-1:0] rd_data,
    output logic                  rd_data_en,
    output logic                  ack,
    output logic                  nack,
    output logic                  op_go,
    output bit_op_t               op,
    output logic [`EE_DATA_W-1:0] tx_byte,
    output logic                  master_nack
);

    main_state_t state;

    logic                  rd_flag;   // latched read request
    logic                  nack_seen;
    logic [`EE_ADDR_W-1:0] addr_q;
    logic [`EE_DATA_W-1:0] wdata_q;
    logic [`EE_DATA_W-1:0] ctrl_wr;
    logic [`EE_DATA_W-1:0] ctrl_rd;
    logic                  strobe_ok;

    assign strobe_ok = (state == st_idle) && (wr || rd);

    // device code, block select, r/w bit
    assign ctrl_wr = {`EE_DEV_CODE, addr_q[`EE_ADDR_W-1:`EE_DATA_W], 1'b0};
    assign ctrl_rd = {`EE_DEV_CODE, addr_q[`EE_ADDR_W-1:`EE_DATA_W], 1'b1};

    // random read fetches a single byte, so always NACK it
    assign master_nack = 1'b1;

    // op and byte follow the state entered with op_go
    always_comb begin
        op      = op_start;
        tx_byte = ctrl_wr;
        case (state)
            st_write_start,
            st_read_start:  op = op_start;
            st_ctrl_write:  op = op_wbyte;
            st_addr_write: begin
                op      = op_wbyte;
                tx_byte = addr_q[`EE_DATA_W-1:0]; // word address
            end
            st_data_write: begin
                op      = op_wbyte;
                tx_byte = wdata_q;
            end
            st_ctrl_read: begin
                op      = op_wbyte;
                tx_byte = ctrl_rd;
            end
            st_data_read:   op = op_rbyte;
            st_stop:        op = op_stop;
            default:        op = op_start;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state      <= st_idle;
            rd_flag    <= 1'b0;
            nack_seen  <= 1'b0;
            rd_data_en <= 1'b0;
            ack        <= 1'b0;
            nack       <= 1'b0;
            op_go      <= 1'b0;
        end else begin
            op_go <= 1'b0;
            ack   <= 1'b0;
            case (state)
                st_idle: begin
                    rd_data_en <= 1'b0; // drops the cycle after ack
                    if (strobe_ok) begin
                        rd_flag   <= !wr; // wr wins
                        nack      <= 1'b0;
                        nack_seen <= 1'b0;
                        state     <= st_ready;
                    end
                end
                st_ready: begin
                    op_go <= 1'b1;
                    state <= st_write_start;
                end
                st_write_start: begin
                    if (op_done) begin
                        op_go <= 1'b1;
                        state <= st_ctrl_write;
                    end
                end
                st_ctrl_write: begin
                    if (op_done) begin
                        op_go <= 1'b1;
                        if (slave_nack) begin
                            nack_seen <= 1'b1;
                            state     <= st_stop;
                        end else begin
                            state <= st_addr_write;
                        end
                    end
                end
                st_addr_write: begin
                    if (op_done) begin
                        op_go <= 1'b1;
                        if (slave_nack) begin
                            nack_seen <= 1'b1;
                            state     <= st_stop;
                        end else if (rd_flag) begin
                            state <= st_read_start; // repeated start
                        end else begin
                            state <= st_data_write;
                        end
                    end
                end
                st_data_write: begin
                    if (op_done) begin
                        op_go     <= 1'b1;
                        nack_seen <= slave_nack;
                        state     <= st_stop;
                    end
                end
                st_read_start: begin
                    if (op_done) begin
                        op_go <= 1'b1;
                        state <= st_ctrl_read;
                    end
                end
                st_ctrl_read: begin
                    if (op_done) begin
                        op_go <= 1'b1;
                        if (slave_nack) begin
                            nack_seen <= 1'b1;
                            state     <= st_stop;
                        end else begin
                            state <= st_data_read;
                        end
                    end
                end
                st_data_read: begin
                    if (op_done) begin
                        rd_data_en <= 1'b1; // byte now on offer
                        op_go      <= 1'b1;
                        state      <= st_stop;
                    end
                end
                st_stop: begin
                    if (op_done) begin
                        state <= st_ackn;
                    end
                end
                st_ackn: begin
                    ack   <= 1'b1;
                    nack  <= nack_seen;
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // request and read payload
    always_ff @(posedge CLK) begin
        if (strobe_ok) begin
            addr_q  <= addr;
            wdata_q <= wr_data;
        end
        if (state == st_data_read && op_done) begin
            rd_data <= rx_byte;
        end
    end

endmodule

`default_nettype wire

// File: eeprom_wr/serial_bit_engine.sv
`default_nettype none
`include "eeprom_cfg.svh"

module serial_bit_engine
    import eeprom_pkg::*;
(
    input  wire                   CLK,
    input  wire                   RESET,
    input  wire                   op_go,
    input  wire bit_op_t          op,
    input  wire [`EE_DATA_W-1:0]  tx_byte,
    input  wire                   master_nack,
    input  wire                   sda_in,
    output logic                  op_done,
    output logic                  slave_nack,
    output logic [`EE_DATA_W-1:0] rx_byte,
    output logic                  scl,
    output logic                  sda_drive_low
);

    localparam int PH_W = $clog2(`EE_PHASES);

    localparam logic [PH_W-1:0] PH_RISE   = PH_W'(1);
    localparam logic [PH_W-1:0] PH_SAMPLE = PH_W'(2);
    localparam logic [PH_W-1:0] PH_LAST   = PH_W'(`EE_PHASES - 1);
    localparam logic [3:0]      ACK_BIT   = 4'(`EE_DATA_W);

    logic                  busy;
    bit_op_t               cur_op;
    logic                  mn_q;
    logic [PH_W-1:0]       phase;
    logic [3:0]            bit_cnt;
    logic [3:0]            last_bit;
    logic [`EE_DATA_W-1:0] shreg;

    // start/stop are a single bit period, bytes carry the ack bit
    assign last_bit = (cur_op == op_wbyte || cur_op == op_rbyte) ? ACK_BIT : 4'd0;
    assign rx_byte  = shreg;

    // SDA level set at phase 0 of a bit
    function automatic logic bit_drive(
        input bit_op_t    o,
        input logic [3:0] b,
        input logic       d_msb,
        input logic       mn
    );
        logic drv;
        case (o)
            op_start: drv = 1'b0;   // release, SDA high before the start edge
            op_stop:  drv = 1'b1;   // low, so it can rise while SCL is high
            op_wbyte: drv = (b < ACK_BIT) ? ~d_msb : 1'b0;
            default:  drv = (b < ACK_BIT) ? 1'b0 : ~mn;
        endcase
        return drv;
    endfunction

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy          <= 1'b0;
            cur_op        <= op_start;
            mn_q          <= 1'b1;
            phase         <= '0;
            bit_cnt       <= '0;
            op_done       <= 1'b0;
            slave_nack    <= 1'b0;
            scl           <= 1'b1; // idle bus
            sda_drive_low <= 1'b0;
        end else begin
            op_done <= 1'b0;
            if (!busy) begin
                if (op_go) begin
                    busy          <= 1'b1;
                    cur_op        <= op;
                    mn_q          <= master_nack;
                    phase         <= '0;
                    bit_cnt       <= '0;
                    scl           <= 1'b0;
                    sda_drive_low <= bit_drive(op, 4'd0, tx_byte[`EE_DATA_W-1], master_nack);
                end
            end else if (phase == PH_LAST) begin
                phase <= '0;
                if (bit_cnt == last_bit) begin
                    busy    <= 1'b0;
                    op_done <= 1'b1;
                    scl     <= (cur_op == op_stop); // low inside a transaction
                end else begin
                    bit_cnt       <= bit_cnt + 4'd1;
                    scl           <= 1'b0;
                    sda_drive_low <= bit_drive(cur_op, bit_cnt + 4'd1,
                                               shreg[`EE_DATA_W-2], mn_q);
                end
            end else begin
                phase <= phase + PH_W'(1);
                scl   <= 1'b1;
                if (phase == PH_RISE) begin
                    // SDA edge while SCL high
                    if (cur_op == op_start) begin
                        sda_drive_low <= 1'b1;
                    end else if (cur_op == op_stop) begin
                        sda_drive_low <= 1'b0;
                    end
                end
                if (phase == PH_SAMPLE && cur_op == op_wbyte && bit_cnt == ACK_BIT) begin
                    slave_nack <= sda_in; // high means no ack
                end
            end
        end
    end

    // tx bits leave MSB first, rx bits enter at the LSB
    always_ff @(posedge CLK) begin
        if (!busy && op_go) begin
            shreg <= tx_byte;
        end else if (busy && bit_cnt < ACK_BIT) begin
            if (cur_op == op_wbyte && phase == PH_LAST) begin
                shreg <= {shreg[`EE_DATA_W-2:0], 1'b0};
            end else if (cur_op == op_rbyte && phase == PH_SAMPLE) begin
                shreg <= {shreg[`EE_DATA_W-2:0], sda_in};
            end
        end
    end

endmodule

`default_nettype wire

// File: common/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    // main transaction FSM, one-hot
    typedef enum logic [10:0] {
        st_idle        = 11'b000_0000_0001,
        st_ready       = 11'b000_0000_0010,
        st_write_start = 11'b000_0000_0100,
        st_ctrl_write  = 11'b000_0000_1000,
        st_addr_write  = 11'b000_0001_0000,
        st_data_write  = 11'b000_0010_0000,
        st_read_start  = 11'b000_0100_0000,
        st_ctrl_read   = 11'b000_1000_0000,
        st_data_read   = 11'b001_0000_0000,
        st_stop        = 11'b010_0000_0000,
        st_ackn        = 11'b100_0000_0000
    } main_state_t;

    // operations handed to the serial bit engine
    typedef enum logic [1:0] {
        op_start = 2'd0, // start or repeated start
        op_stop  = 2'd1,
        op_wbyte = 2'd2, // 8 bits out, slave ack in
        op_rbyte = 2'd3  // 8 bits in, master ack/nack out
    } bit_op_t;

endpackage

`default_nettype wire

// File: common/eeprom_cfg.svh
`ifndef EEPROM_CFG_SVH
`define EEPROM_CFG_SVH

// 24C16 class part, 2048 bytes
`define EE_ADDR_W 11

// parallel bus and memory word
`define EE_DATA_W 8

// device type code, upper nibble of the control byte
`define EE_DEV_CODE 4'b1010

// CLK cycles per SCL bit period
`define EE_PHASES 4

`endif
